/* design/agcPkg.sv */
// shared widths, configuration and host write structs, register addresses and reset values
`default_nettype none

package agcPkg;

    typedef logic signed [17:0] sampleT;        // signed receive sample from the front end
    typedef logic [16:0] levelT;                // rectified signal magnitude
    typedef logic [7:0] logT;                   // log2 value, exponent in [7:4] and fraction in [3:0]
    typedef logic [31:0] accT;                  // loop integrator
    typedef logic [17:0] gainT;                 // gain word for the variable-gain stage
    typedef logic [3:0] shiftT;                 // loop-gain shift, larger means a faster loop
    typedef logic [31:0] busDataT;              // host data word
    typedef logic [1:0] regAddrT;               // host register address

    localparam int LIN_WIDTH = 16;              // log block works on the upper bits of the level
    localparam int FRAC_WIDTH = 4;              // fraction bits of the log value

    // configuration that the register bank hands to the loop filter
    typedef struct packed {
        logic freeze;                           // holds the integrator when set
        shiftT gainShift;                       // error is shifted left by this amount
        logT refLevel;                          // target level in log2 units
    } agcCfgT;

    // one host write, taken on a cycle with wrEn high
    typedef struct packed {
        regAddrT addr;                          // register that takes the data
        busDataT data;                          // full 32-bit word, no byte lanes
    } busWriteT;

    localparam regAddrT ADDR_CTRL = 2'd0;       // freeze in bit 0, gainShift in bits 4 to 1
    localparam regAddrT ADDR_REF = 2'd1;        // refLevel in bits 7 to 0
    localparam regAddrT ADDR_ACC = 2'd2;        // write presets the integrator, read returns it
    localparam regAddrT ADDR_LEVEL = 2'd3;      // read-only view of rxLevel

    localparam logic RESET_FREEZE = 1'b0;       // loop runs out of reset
    localparam shiftT RESET_SHIFT = 4'd4;       // moderate loop bandwidth
    localparam logT RESET_REF = 8'hA0;          // exponent 10 with a zero fraction
    localparam accT RESET_ACC = 32'h8000_0000;  // mid-scale gain

endpackage

`default_nettype wire

/* design/agcLevelDetect.sv */
// level detector that rectifies and saturates the receive sample on each symbol strobe
`timescale 1ns/1ps
`default_nettype none

module agcLevelDetect (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            symEn,       // strobe from the bit synchronizer at the best instant
    input  wire agcPkg::sampleT  rx,          // signed receive sample
    output agcPkg::levelT        rxLevel,     // magnitude of the last strobed sample
    output logic                 levelValid   // high for one cycle when rxLevel is new
);

    import agcPkg::*;

    sampleT negRx;                            // two's complement negation of the sample
    logic [17:0] mag;                         // rectified sample, one bit wider than the level
    levelT satLevel;                          // magnitude clipped to the level width

    assign negRx = -rx;                       // the most negative code wraps onto itself here
    assign mag = rx[17] ? negRx : rx;         // bit 17 ends up set only for the most negative code

    // 2**17 does not fit in 17 bits so it is pinned to full scale
    assign satLevel = mag[17] ? '1 : mag[16:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxLevel <= '0;                    // level reads as zero until the first symbol
            levelValid <= 1'b0;
        end else begin
            levelValid <= symEn;              // strobe travels with the captured level
            if (symEn) begin
                rxLevel <= satLevel;          // level holds between strobes
            end
        end
    end

endmodule

`default_nettype wire

/* design/agcLog2.sv */
// two-stage pipeline from the linear level to a piecewise-linear base-2 logarithm
`timescale 1ns/1ps
`default_nettype none

module agcLog2 (
    input  wire logic           clk,
    input  wire logic           rstN,
    input  wire logic           levelValid,  // new level on this cycle
    input  wire agcPkg::levelT  rxLevel,     // linear magnitude from the level detector
    output logic                logValid,    // log2Mag is new, two cycles after levelValid
    output agcPkg::logT         log2Mag      // exponent in the upper nibble, fraction below
);

    import agcPkg::*;

    localparam int EXP_WIDTH = $clog2(LIN_WIDTH);  // 4 bits of exponent for a 16-bit word

    logic [LIN_WIDTH-1:0] linear;            // upper bits of the level, the lsb is dropped
    logic [EXP_WIDTH-1:0] leadPos;           // position of the leading one in linear

    logic [LIN_WIDTH-1:0] word1;             // stage one copy of the input word
    logic [EXP_WIDTH-1:0] exp1;              // stage one exponent
    logic valid1;                            // stage one holds a live sample

    logic [LIN_WIDTH-1:0] normWord;          // word1 shifted so the leading one sits at the msb
    logic [FRAC_WIDTH-1:0] frac;             // bits just below the leading one

    assign linear = rxLevel[16:1];           // log works on 16 bits like the older receiver

    // priority search from the lsb up so the highest set bit wins
    always_comb begin
        leadPos = '0;                        // an all-zero word gives exponent zero
        for (int i = 0; i < LIN_WIDTH; i++) begin
            if (linear[i]) begin
                leadPos = EXP_WIDTH'(i);
            end
        end
    end

    // shifting left drops the leading one off the top, zeros fill in below
    assign normWord = word1 << (EXP_WIDTH'(LIN_WIDTH - 1) - exp1);
    assign frac = normWord[LIN_WIDTH-2 -: FRAC_WIDTH];  // zero word stays zero after the shift

    // stage one captures the exponent and the word it came from
    always_ff @(posedge clk) begin
        if (!rstN) begin
            valid1 <= 1'b0;
        end else begin
            valid1 <= levelValid;
        end
    end

    always_ff @(posedge clk) begin
        word1 <= linear;                     // payload moves every cycle, the valid bit qualifies it
        exp1 <= leadPos;
    end

    // stage two forms the fraction and the final log word
    always_ff @(posedge clk) begin
        if (!rstN) begin
            logValid <= 1'b0;
        end else begin
            logValid <= valid1;              // each stage can carry a different sample
        end
    end

    always_ff @(posedge clk) begin
        log2Mag <= {exp1, frac};             // piecewise-linear between powers of two
    end

endmodule

`default_nettype wire

/* design/agcRegs.sv */
// host register bank with configuration, read decode and the accumulator preset pulse
`timescale 1ns/1ps
`default_nettype none

module agcRegs (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              wrEn,       // host write strobe, one cycle per write
    input  wire agcPkg::busWriteT  busWr,      // address and data of the write
    input  wire agcPkg::regAddrT   rdAddr,     // host read address
    input  wire agcPkg::accT       acc,        // live integrator from the loop filter
    input  wire agcPkg::levelT     rxLevel,    // live signal level from the detector
    output agcPkg::busDataT        rdData,     // read data, follows rdAddr without a clock
    output agcPkg::agcCfgT         cfg,        // loop configuration, always driven
    output logic                   accLoad,    // loads accPreset into the integrator
    output agcPkg::accT            accPreset   // value to load on accLoad
);

    import agcPkg::*;

    logic wrCtrl;                             // write to the control register this cycle
    logic wrRef;                              // write to the reference register this cycle

    assign wrCtrl = wrEn && (busWr.addr == ADDR_CTRL);
    assign wrRef = wrEn && (busWr.addr == ADDR_REF);

    // the preset goes straight to the filter so the integrator loads on the write edge
    assign accLoad = wrEn && (busWr.addr == ADDR_ACC);
    assign accPreset = busWr.data;           // only meaningful while accLoad is high

    // configuration registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            cfg.freeze <= RESET_FREEZE;
            cfg.gainShift <= RESET_SHIFT;
            cfg.refLevel <= RESET_REF;
        end else begin
            if (wrCtrl) begin
                cfg.freeze <= busWr.data[0];          // freeze sits in bit 0
                cfg.gainShift <= busWr.data[4:1];     // shift sits just above it
            end
            if (wrRef) begin
                cfg.refLevel <= busWr.data[7:0];      // upper data bits are ignored
            end
        end
    end

    // read mux, unused bits read as zero
    always_comb begin
        rdData = '0;
        case (rdAddr)
            ADDR_CTRL: begin
                rdData[0] = cfg.freeze;
                rdData[4:1] = cfg.gainShift;
            end
            ADDR_REF: begin
                rdData[7:0] = cfg.refLevel;
            end
            ADDR_ACC: begin
                rdData = acc;                 // live integrator, not the last preset
            end
            ADDR_LEVEL: begin
                rdData[16:0] = rxLevel;       // level of the last strobed symbol
            end
            default: begin
                rdData = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/agcLoopFilter.sv */
// loop filter with the error term, shifted saturating integrator, freeze, preset and gain output
`timescale 1ns/1ps
`default_nettype none

module agcLoopFilter (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            logValid,   // new log2Mag this cycle
    input  wire agcPkg::logT     log2Mag,    // measured level in log2 units
    input  wire agcPkg::agcCfgT  cfg,        // freeze, shift and reference from the registers
    input  wire logic            accLoad,    // preset request from the host
    input  wire agcPkg::accT     accPreset,  // value to load on accLoad
    output agcPkg::accT          acc,        // integrator, also read back by the host
    output agcPkg::gainT         agcGain     // gain word to the variable-gain stage
);

    import agcPkg::*;

    localparam int ERR_WIDTH = $bits(logT) + 1;   // reference minus level needs a sign bit
    localparam int SUM_WIDTH = $bits(accT) + 2;   // one bit for overflow and one for sign

    logic signed [ERR_WIDTH-1:0] error;          // positive when the signal is weak
    logic signed [SUM_WIDTH-1:0] errExt;         // error widened to the sum width
    logic signed [SUM_WIDTH-1:0] step;           // error scaled by the loop gain
    logic signed [SUM_WIDTH-1:0] sum;            // unclamped integrator update
    accT accNext;                                // update clamped to the accumulator range

    // both operands are unsigned logs so zero-extend before the subtract
    assign error = $signed({1'b0, cfg.refLevel}) - $signed({1'b0, log2Mag});

    assign errExt = {{(SUM_WIDTH - ERR_WIDTH){error[ERR_WIDTH-1]}}, error};
    assign step = errExt <<< cfg.gainShift;      // at most 24 significant bits, never overflows

    assign sum = $signed({2'b00, acc}) + step;   // acc is unsigned so it gets two zero bits

    // clamp to zero below and to full scale above, the sum never wraps
    always_comb begin
        if (sum[SUM_WIDTH-1]) begin
            accNext = '0;                        // went negative, gain floors at zero
        end else if (sum[SUM_WIDTH-2]) begin
            accNext = '1;                        // carried past bit 31, gain pins at maximum
        end else begin
            accNext = sum[$bits(accT)-1:0];
        end
    end

    // integrator, the preset beats a sample that lands on the same edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            acc <= RESET_ACC;                    // mid-scale gain until the loop pulls in
        end else if (accLoad) begin
            acc <= accPreset;                    // sample on this edge is dropped
        end else if (logValid && !cfg.freeze) begin
            acc <= accNext;
        end
    end

    // gain is the top of the integrator so it moves slowly with small errors
    assign agcGain = acc[$bits(accT)-1 -: $bits(gainT)];

endmodule

`default_nettype wire

/* design/pcmAgc.sv */
// top level joining the level detector, log2 pipeline, register bank and loop filter
`timescale 1ns/1ps
`default_nettype none

module pcmAgc (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire logic              symEn,     // symbol strobe from the bit synchronizer
    input  wire agcPkg::sampleT    rx,        // signed receive sample
    input  wire logic              wrEn,      // host write strobe
    input  wire agcPkg::busWriteT  busWr,     // host write address and data
    input  wire agcPkg::regAddrT   rdAddr,    // host read address
    output agcPkg::busDataT        rdData,    // host read data
    output agcPkg::levelT          rxLevel,   // current signal level
    output agcPkg::gainT           agcGain    // gain word, three cycles behind the sample
);

    import agcPkg::*;

    logic levelValid;                         // detector has a new level
    logic logValid;                           // log pipeline has a new value
    logT log2Mag;                             // level in log2 units
    agcCfgT cfg;                              // loop configuration from the registers
    logic accLoad;                            // host preset pulse
    accT accPreset;                           // host preset value
    accT acc;                                 // integrator for the read-back

    agcLevelDetect levelDetect (
        .clk        (clk),
        .rstN       (rstN),
        .symEn      (symEn),
        .rx         (rx),
        .rxLevel    (rxLevel),
        .levelValid (levelValid)
    );

    agcLog2 log2 (
        .clk        (clk),
        .rstN       (rstN),
        .levelValid (levelValid),
        .rxLevel    (rxLevel),
        .logValid   (logValid),
        .log2Mag    (log2Mag)
    );

    agcRegs regs (
        .clk        (clk),
        .rstN       (rstN),
        .wrEn       (wrEn),
        .busWr      (busWr),
        .rdAddr     (rdAddr),
        .acc        (acc),
        .rxLevel    (rxLevel),
        .rdData     (rdData),
        .cfg        (cfg),
        .accLoad    (accLoad),
        .accPreset  (accPreset)
    );

    agcLoopFilter loopFilter (
        .clk        (clk),
        .rstN       (rstN),
        .logValid   (logValid),
        .log2Mag    (log2Mag),
        .cfg        (cfg),
        .accLoad    (accLoad),
        .accPreset  (accPreset),
        .acc        (acc),
        .agcGain    (agcGain)
    );

endmodule

`default_nettype wire

/* verification/pcmAgc_props.sv */
// concurrent assertions on the loop filter integrator, gain word and preset pulse, with the bind
`timescale 1ns/1ps
`default_nettype none

module pcmAgcProps (
    input wire logic            clk,
    input wire logic            rstN,
    input wire agcPkg::agcCfgT  cfg,       // freeze and shift as the filter sees them
    input wire logic            accLoad,   // host preset pulse
    input wire agcPkg::accT     acc,       // integrator
    input wire agcPkg::gainT    agcGain    // gain word driven to the gain stage
);

    import agcPkg::*;

    // a frozen loop only moves on a preset
    frozenHold: assert property (
        @(posedge clk) disable iff (!rstN)
        (cfg.freeze && !accLoad) |=> $stable(acc)
    ) else $error("accumulator moved while freeze was set and no preset was issued");

    // the gain word is the top of the integrator at every edge
    gainIsTop: assert property (
        @(posedge clk) disable iff (!rstN)
        agcGain == acc[$bits(accT)-1 -: $bits(gainT)]
    ) else $error("gain word does not match the upper accumulator bits");

    // the preset is a single-cycle strobe
    loadPulse: assert property (
        @(posedge clk) disable iff (!rstN)
        accLoad |=> !accLoad
    ) else $error("accumulator preset stayed high for more than one cycle");

endmodule

bind agcLoopFilter pcmAgcProps props (
    .clk     (clk),
    .rstN    (rstN),
    .cfg     (cfg),
    .accLoad (accLoad),
    .acc     (acc),
    .agcGain (agcGain)
);

`default_nettype wire

/* verification/tbPcmAgc.sv */
// directed testbench for the PCM AGC with reference model, LFSR, tests, watchdog and summary
`timescale 1ns/1ps
`default_nettype none

module tbPcmAgc;

    import agcPkg::*;

    localparam int CLK_PERIOD = 4;                 // ns
    localparam int RESET_CYCLES = 8;
    localparam int REG_TEST_CYCLES = 20;           // cycle budgets of the tests, summed for the watchdog
    localparam int LEVEL_TEST_CYCLES = 80;
    localparam int STEP_TEST_CYCLES = 180;
    localparam int FREEZE_TEST_CYCLES = 50;
    localparam int SAT_TEST_CYCLES = 50;
    localparam int BURST_TEST_CYCLES = 50;
    localparam int MARGIN_CYCLES = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + REG_TEST_CYCLES + LEVEL_TEST_CYCLES +
        STEP_TEST_CYCLES + FREEZE_TEST_CYCLES + SAT_TEST_CYCLES + BURST_TEST_CYCLES + MARGIN_CYCLES;

    logic clk;
    logic rstN;
    logic symEn;
    sampleT rx;
    logic wrEn;
    busWriteT busWr;
    regAddrT rdAddr;
    busDataT rdData;
    levelT rxLevel;
    gainT agcGain;

    logic [31:0] lfsrState;                        // Galois LFSR behind all random samples
    accT modelAcc;                                 // expected integrator
    shiftT modelShift;                             // expected loop-gain shift
    logT modelRef;                                 // expected reference level
    logic modelFreeze;                             // expected freeze bit
    int checkCount = 0;
    int errorCount = 0;

    pcmAgc dut (
        .clk     (clk),
        .rstN    (rstN),
        .symEn   (symEn),
        .rx      (rx),
        .wrEn    (wrEn),
        .busWr   (busWr),
        .rdAddr  (rdAddr),
        .rdData  (rdData),
        .rxLevel (rxLevel),
        .agcGain (agcGain)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;           // 4 ns period

    // one LFSR step per bit, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h8020_0003;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsrBit()};
        end
        return val;
    endfunction

    // random sample scaled down by a random amount so many exponents show up
    function automatic sampleT randomSample();
        sampleT raw;
        logic [3:0] scale;
        raw = sampleT'(randBits(18));
        scale = 4'(randBits(4));
        return raw >>> scale;
    endfunction

    // magnitude of the sample, the one value that overflows 17 bits is pinned to full scale
    function automatic levelT levelOf(input sampleT s);
        int mag;
        mag = (s < 0) ? -int'(s) : int'(s);
        if (mag > 131071) begin
            mag = 131071;
        end
        return levelT'(mag);
    endfunction

    // exponent is the leading one of the upper 16 level bits, fraction the four bits below it
    function automatic logT logOf(input levelT level);
        logic [15:0] lin;
        int msb;
        int pos;
        logic [3:0] frac;
        lin = level[16:1];
        msb = -1;
        frac = '0;
        for (int i = 15; i >= 0; i--) begin
            if (msb < 0 && lin[i]) begin
                msb = i;
            end
        end
        if (msb < 0) begin
            return 8'h00;                          // no signal at all
        end
        for (int k = 0; k < 4; k++) begin
            pos = msb - 1 - k;
            frac[3 - k] = (pos >= 0) ? lin[pos] : 1'b0;
        end
        return {4'(msb), frac};
    endfunction

    // one integrator update, clamped to the unsigned 32-bit range
    function automatic accT accStep(input accT accIn, input logT mag, input shiftT shift,
                                    input logT refLvl);
        longint err;
        longint sum;
        err = longint'(refLvl) - longint'(mag);
        sum = longint'(accIn) + err * (longint'(1) << shift);
        if (sum < 0) begin
            return '0;
        end
        if (sum > 64'h0000_0000_FFFF_FFFF) begin
            return '1;
        end
        return accT'(sum);
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        assert (actual === expected) else begin
            errorCount++;
            $display("[ERROR] %s expected %h actual %h", testName, expected, actual);
        end
    endtask

    task automatic tickCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // write pulse of one cycle followed by an idle cycle, ends on a falling edge
    task automatic writeReg(input regAddrT addr, input busDataT data);
        wrEn = 1'b1;
        busWr.addr = addr;
        busWr.data = data;
        @(negedge clk);
        wrEn = 1'b0;
        @(negedge clk);
    endtask

    task automatic expectReg(input string testName, input regAddrT addr, input busDataT expected);
        busDataT data;
        rdAddr = addr;
        #1 data = rdData;                          // read mux settles well before the rising edge
        checkValue(testName, expected, data);
        @(negedge clk);
    endtask

    task automatic setCtrl(input logic freeze, input shiftT shift);
        writeReg(ADDR_CTRL, {27'b0, shift, freeze});
        modelFreeze = freeze;
        modelShift = shift;
    endtask

    task automatic presetAcc(input accT value);
        writeReg(ADDR_ACC, value);
        modelAcc = value;                          // preset lands on the write edge
    endtask

    // single strobe, returns on the falling edge after the capturing edge
    task automatic sendSymbol(input sampleT s);
        symEn = 1'b1;
        rx = s;
        @(negedge clk);
        symEn = 1'b0;
        if (!modelFreeze) begin
            modelAcc = accStep(modelAcc, logOf(levelOf(s)), modelShift, modelRef);
        end
    endtask

    task automatic testResetValues();
        expectReg("reset ctrl", ADDR_CTRL, {27'b0, RESET_SHIFT, RESET_FREEZE});
        expectReg("reset ref", ADDR_REF, {24'b0, RESET_REF});
        expectReg("reset acc", ADDR_ACC, RESET_ACC);
        expectReg("reset level", ADDR_LEVEL, '0);
        writeReg(ADDR_CTRL, 32'hFFFF_FF15);        // freeze set, shift 10, junk above
        writeReg(ADDR_REF, 32'h1234_5678);
        expectReg("readback ctrl", ADDR_CTRL, 32'h0000_0015);
        expectReg("readback ref", ADDR_REF, 32'h0000_0078);
        setCtrl(RESET_FREEZE, RESET_SHIFT);        // back to the loop defaults
        writeReg(ADDR_REF, {24'b0, RESET_REF});
    endtask

    task automatic testLevelDetect();
        sampleT corner [4];
        sampleT s;
        corner = '{18'sh1FFFF, 18'sh20000, 18'sh00000, -18'sd1};
        for (int i = 0; i < 16; i++) begin
            s = (i < 4) ? corner[i] : randomSample();
            sendSymbol(s);
            checkValue("level capture", levelOf(s), rxLevel);
            rx = (s == 0) ? 18'sd100 : 18'sd0;     // new sample with no strobe must not show up
            tickCycles(2);
            checkValue("level hold", levelOf(s), rxLevel);
            expectReg("level read", ADDR_LEVEL, {15'b0, levelOf(s)});
        end
    endtask

    task automatic testLoopStep();
        shiftT shifts [4];
        sampleT samples [4];
        shifts = '{4'd0, 4'd5, 4'd10, 4'd15};
        samples = '{18'sd700, -18'sd1500, 18'sd90000, -18'sd40000};  // weak, weak, strong, strong
        tickCycles(4);                             // let earlier symbols leave the pipeline
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                setCtrl(1'b0, shifts[i]);
                presetAcc(32'h8000_0000 + (j << 20));
                expectReg("step preset", ADDR_ACC, modelAcc);
                sendSymbol(samples[j]);
                tickCycles(3);                     // gain moves on the third edge after capture
                checkValue("step gain", modelAcc[31:14], agcGain);
                expectReg("step acc", ADDR_ACC, modelAcc);
            end
        end
    endtask

    task automatic testFreeze();
        accT accHold;
        tickCycles(4);
        setCtrl(1'b0, 4'd12);                      // shift large enough to move the gain word
        presetAcc(32'h8000_0000);
        setCtrl(1'b1, 4'd12);
        accHold = modelAcc;
        for (int i = 0; i < 4; i++) begin
            sendSymbol(18'sd500);
            tickCycles(3);
            checkValue("freeze gain", accHold[31:14], agcGain);
            expectReg("freeze acc", ADDR_ACC, accHold);
        end
        setCtrl(1'b0, 4'd12);
        sendSymbol(18'sd500);
        tickCycles(3);
        checkValue("unfreeze gain", modelAcc[31:14], agcGain);
        expectReg("unfreeze acc", ADDR_ACC, modelAcc);
    endtask

    task automatic testSaturation();
        tickCycles(4);
        setCtrl(1'b0, 4'd15);
        presetAcc(32'hFFFF_FF00);
        for (int i = 0; i < 2; i++) begin
            sendSymbol(18'sd0);                    // no signal pushes the gain up
            tickCycles(3);
            checkValue("sat gain top", 32'h0003_FFFF, agcGain);
            expectReg("sat acc top", ADDR_ACC, 32'hFFFF_FFFF);
        end
        presetAcc(32'h0000_0100);
        for (int i = 0; i < 2; i++) begin
            sendSymbol(18'sh1FFFF);                // full scale pulls the gain down
            tickCycles(3);
            checkValue("sat gain bottom", 32'h0000_0000, agcGain);
            expectReg("sat acc bottom", ADDR_ACC, 32'h0000_0000);
        end
    endtask

    task automatic testBackToBack();
        sampleT s;
        tickCycles(4);
        setCtrl(1'b0, 4'd6);
        presetAcc(32'h8000_0000);
        symEn = 1'b1;                              // strobe stays high for 20 symbols in a row
        for (int i = 0; i < 20; i++) begin
            s = randomSample();
            rx = s;
            modelAcc = accStep(modelAcc, logOf(levelOf(s)), modelShift, modelRef);
            @(negedge clk);
        end
        symEn = 1'b0;
        tickCycles(4);
        checkValue("burst gain", modelAcc[31:14], agcGain);
        expectReg("burst acc", ADDR_ACC, modelAcc);
    endtask

    // ends a run that has stopped making progress
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        symEn = 1'b0;
        rx = '0;
        wrEn = 1'b0;
        busWr = '0;
        rdAddr = ADDR_CTRL;
        lfsrState = 32'h0143_adcd;
        modelAcc = RESET_ACC;
        modelShift = RESET_SHIFT;
        modelRef = RESET_REF;
        modelFreeze = RESET_FREEZE;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        testResetValues();
        testLevelDetect();
        testLoopStep();
        testFreeze();
        testSaturation();
        testBackToBack();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/agcPkg.sv
design/agcLevelDetect.sv
design/agcLog2.sv
design/agcRegs.sv
design/agcLoopFilter.sv
design/pcmAgc.sv
verification/pcmAgc_props.sv
verification/tbPcmAgc.sv
